// ==== hw/lisp_pkg.sv ====
`default_nettype none

package lisp_pkg;

	// Opcode numbering shared with the assembler
	typedef enum logic [4:0] {
		OP_NOP    = 5'd0,
		OP_POP    = 5'd3,
		OP_LOAD   = 5'd4,
		OP_STORE  = 5'd5,
		OP_ADD    = 5'd6,
		OP_SUB    = 5'd7,
		OP_GTR    = 5'd9,
		OP_GTE    = 5'd10,
		OP_EQ     = 5'd11,
		OP_NEQ    = 5'd12,
		OP_DUP    = 5'd13,
		OP_AND    = 5'd16,
		OP_OR     = 5'd17,
		OP_XOR    = 5'd18,
		OP_PUSH   = 5'd25,
		OP_GOTO   = 5'd26,
		OP_BFALSE = 5'd27
	} opcode_e;

	typedef enum logic [2:0] {
		ST_FETCH,
		ST_DECODE,
		ST_GOT_NOS,
		ST_LOAD_TOS,
		ST_PUSH_MEM
	} state_e;

	typedef enum logic [1:0] {
		SP_CURRENT,
		SP_DECREMENT,
		SP_INCREMENT
	} sp_sel_e;

	typedef enum logic [1:0] {
		TOS_CURRENT,
		TOS_PARAM,
		TOS_ALU,
		TOS_MEM
	} tos_sel_e;

	typedef enum logic [1:0] {
		MA_IP_NEXT,
		MA_SP,
		MA_SP_MINUS_ONE,
		MA_TOS
	} ma_sel_e;

	typedef enum logic {
		MW_TOS,
		MW_MEM_READ
	} mw_sel_e;

	typedef enum logic [1:0] {
		IP_CURRENT,
		IP_NEXT,
		IP_BRANCH
	} ip_sel_e;

	// One cycle's worth of datapath control
	typedef struct packed {
		sp_sel_e  sp_sel;
		tos_sel_e tos_sel;
		ma_sel_e  ma_sel;
		mw_sel_e  mw_sel;
		ip_sel_e  ip_sel;
		opcode_e  alu_op;
		logic     write_enable;
	} core_ctrl_t;

endpackage

`default_nettype wire

// ==== hw/insn_unpack.sv ====
`timescale 1ns/1ps
`default_nettype none

module insn_unpack import lisp_pkg::*; #(
	parameter int WORD_SIZE = 20
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [WORD_SIZE - 1:0] mem_read_value,
	input  state_e                 state,
	input  logic [1:0]             ip_slot,
	output opcode_e                opcode,
	output logic [WORD_SIZE - 1:0] param,
	output logic                   has_param
);

	logic [WORD_SIZE - 1:0] latched_word;
	logic [WORD_SIZE - 1:0] cur_word;

	// The fetched word is only on the bus during DECODE
	always_ff @(posedge clk)
	begin
		if (rst)
			latched_word <= '0;
		else if (state == ST_DECODE)
			latched_word <= mem_read_value;
	end

	// Slot 0 is the most significant; the tail of the word is the parameter
	always_comb
	begin
		cur_word = (state == ST_DECODE) ? mem_read_value : latched_word;
		case (ip_slot)
			2'd0:
			begin
				opcode = opcode_e'(cur_word[WORD_SIZE - 1 -: 5]);
				param = {{5{cur_word[WORD_SIZE - 6]}}, cur_word[WORD_SIZE - 6:0]};
			end
			2'd1:
			begin
				opcode = opcode_e'(cur_word[WORD_SIZE - 6 -: 5]);
				param = {{10{cur_word[WORD_SIZE - 11]}}, cur_word[WORD_SIZE - 11:0]};
			end
			2'd2:
			begin
				opcode = opcode_e'(cur_word[WORD_SIZE - 11 -: 5]);
				param = {{15{cur_word[WORD_SIZE - 16]}}, cur_word[WORD_SIZE - 16:0]};
			end
			default:
			begin
				// Last slot leaves no room for a parameter
				opcode = opcode_e'(cur_word[WORD_SIZE - 16 -: 5]);
				param = '0;
			end
		endcase
		has_param = opcode[4:3] == 2'b11;
	end

endmodule

`default_nettype wire

// ==== hw/stack_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module stack_alu import lisp_pkg::*; #(
	parameter int WORD_SIZE = 20
) (
	input  core_ctrl_t             ctrl,
	input  logic [WORD_SIZE - 1:0] top_of_stack,
	input  logic [WORD_SIZE - 1:0] stack_pointer,
	input  logic [WORD_SIZE - 1:0] mem_read_value,
	input  logic [WORD_SIZE - 1:0] param,
	output logic [WORD_SIZE - 1:0] alu_result,
	output logic                   is_zero
);

	logic                   address_arith;
	logic [WORD_SIZE - 1:0] op0;
	logic [WORD_SIZE - 1:0] op1;
	logic                   subtract;
	logic [WORD_SIZE:0]     op1_ext;
	logic [WORD_SIZE:0]     sum;
	logic                   negative;
	logic                   zero;
	logic                   compare_bit;

	// Operand muxes follow from the rest of the control word
	always_comb
	begin
		address_arith = ctrl.ma_sel == MA_SP_MINUS_ONE;
		op0 = address_arith ? stack_pointer : top_of_stack;
		if (address_arith)
			op1 = {{(WORD_SIZE - 1){1'b0}}, 1'b1};
		else if (ctrl.tos_sel == TOS_ALU)
			op1 = mem_read_value;
		else
			op1 = param;
	end

	// One adder, one bit wider so signed compares cannot overflow
	always_comb
	begin
		subtract = ctrl.alu_op != OP_ADD;
		op1_ext = {op1[WORD_SIZE - 1], op1} ^ {(WORD_SIZE + 1){subtract}};
		sum = {op0[WORD_SIZE - 1], op0} + op1_ext + {{WORD_SIZE{1'b0}}, subtract};
		negative = sum[WORD_SIZE];
		zero = sum[WORD_SIZE - 1:0] == '0;
	end

	always_comb
	begin
		compare_bit = 1'b0;
		case (ctrl.alu_op)
			OP_ADD, OP_SUB: alu_result = sum[WORD_SIZE - 1:0];
			OP_GTR:
			begin
				compare_bit = !negative && !zero;
				alu_result = {{(WORD_SIZE - 1){1'b0}}, compare_bit};
			end
			OP_GTE:
			begin
				compare_bit = !negative;
				alu_result = {{(WORD_SIZE - 1){1'b0}}, compare_bit};
			end
			OP_EQ:
			begin
				compare_bit = zero;
				alu_result = {{(WORD_SIZE - 1){1'b0}}, compare_bit};
			end
			OP_NEQ:
			begin
				compare_bit = !zero;
				alu_result = {{(WORD_SIZE - 1){1'b0}}, compare_bit};
			end
			OP_AND: alu_result = op0 & op1;
			OP_OR: alu_result = op0 | op1;
			OP_XOR: alu_result = op0 ^ op1;
			// Anything else passes operand 0, so the zero flag tests it
			default: alu_result = op0;
		endcase
		is_zero = alu_result == '0;
	end

endmodule

`default_nettype wire

// ==== hw/stack_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module stack_datapath import lisp_pkg::*; #(
	parameter int MEM_SIZE = 8192,
	parameter int WORD_SIZE = 20
) (
	input  logic                   clk,
	input  logic                   rst,
	input  core_ctrl_t             ctrl,
	input  logic [WORD_SIZE - 1:0] param,
	input  logic [WORD_SIZE - 1:0] alu_result,
	input  logic [WORD_SIZE - 1:0] mem_read_value,
	input  logic                   has_param,
	input  logic                   is_zero,
	output logic [WORD_SIZE - 1:0] top_of_stack,
	output logic [WORD_SIZE - 1:0] stack_pointer,
	output logic [1:0]             ip_slot,
	output logic                   tos_zero,
	output logic [WORD_SIZE - 1:0] memory_address,
	output logic [WORD_SIZE - 1:0] mem_write_value,
	output logic                   mem_write_enable
);

	// Word address in the upper bits, slot index in the low two
	localparam int IP_WIDTH = WORD_SIZE + 2;

	logic [WORD_SIZE - 1:0] top_of_stack_next;
	logic [WORD_SIZE - 1:0] stack_pointer_next;
	logic [IP_WIDTH - 1:0]  instruction_pointer;
	logic [IP_WIDTH - 1:0]  ip_next;
	logic [IP_WIDTH - 1:0]  ip_word_base;

	always_comb
	begin
		case (ctrl.sp_sel)
			SP_DECREMENT: stack_pointer_next = stack_pointer - 1'b1;
			SP_INCREMENT: stack_pointer_next = stack_pointer + 1'b1;
			default: stack_pointer_next = stack_pointer;
		endcase
	end

	always_comb
	begin
		case (ctrl.tos_sel)
			TOS_PARAM: top_of_stack_next = param;
			TOS_ALU: top_of_stack_next = alu_result;
			TOS_MEM: top_of_stack_next = mem_read_value;
			default: top_of_stack_next = top_of_stack;
		endcase
	end

	// An opcode with a parameter uses up the rest of its word
	always_comb
	begin
		ip_word_base = {instruction_pointer[IP_WIDTH - 1:2], 2'b00};
		case (ctrl.ip_sel)
			IP_NEXT:
			begin
				if (has_param)
					ip_next = ip_word_base + IP_WIDTH'(4);
				else
					ip_next = instruction_pointer + 1'b1;
			end
			IP_BRANCH: ip_next = ip_word_base + {param, 2'b00};
			default: ip_next = instruction_pointer;
		endcase
	end

	always_comb
	begin
		case (ctrl.ma_sel)
			MA_SP: memory_address = stack_pointer;
			// The ALU forms sp - 1 for pushes
			MA_SP_MINUS_ONE: memory_address = alu_result;
			MA_TOS: memory_address = top_of_stack;
			default: memory_address = ip_next[IP_WIDTH - 1:2];
		endcase

		if (ctrl.mw_sel == MW_MEM_READ)
			mem_write_value = mem_read_value;
		else
			mem_write_value = top_of_stack;
	end

	assign mem_write_enable = ctrl.write_enable;
	assign ip_slot = instruction_pointer[1:0];
	assign tos_zero = is_zero;

	// Pointer starts at the last slot so the first step lands on word 0
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			top_of_stack <= '0;
			stack_pointer <= WORD_SIZE'(MEM_SIZE - 8);
			instruction_pointer <= '1;
		end
		else
		begin
			top_of_stack <= top_of_stack_next;
			stack_pointer <= stack_pointer_next;
			instruction_pointer <= ip_next;
		end
	end

endmodule

`default_nettype wire

// ==== hw/stack_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module stack_sequencer import lisp_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  opcode_e    opcode,
	input  logic       tos_zero,
	output state_e     state,
	output core_ctrl_t ctrl
);

	state_e state_next;
	logic   branch_pending;
	logic   branch_pending_next;

	always_comb
	begin
		ctrl.sp_sel = SP_CURRENT;
		ctrl.tos_sel = TOS_CURRENT;
		ctrl.ma_sel = MA_IP_NEXT;
		ctrl.mw_sel = MW_TOS;
		ctrl.ip_sel = IP_CURRENT;
		ctrl.alu_op = opcode;
		ctrl.write_enable = 1'b0;
		state_next = state;
		branch_pending_next = 1'b0;

		case (state)
			ST_FETCH:
			begin
				ctrl.ip_sel = IP_NEXT;
				state_next = ST_DECODE;
			end

			ST_DECODE:
			begin
				case (opcode)
					OP_PUSH, OP_DUP:
					begin
						// Spill TOS below the stack pointer
						ctrl.sp_sel = SP_DECREMENT;
						ctrl.ma_sel = MA_SP_MINUS_ONE;
						ctrl.alu_op = OP_SUB;
						ctrl.write_enable = 1'b1;
						ctrl.mw_sel = MW_TOS;
						if (opcode == OP_PUSH)
							ctrl.tos_sel = TOS_PARAM;
						state_next = ST_FETCH;
					end

					OP_LOAD:
					begin
						ctrl.ma_sel = MA_TOS;
						state_next = ST_PUSH_MEM;
					end

					OP_POP:
					begin
						ctrl.ma_sel = MA_SP;
						ctrl.sp_sel = SP_INCREMENT;
						state_next = ST_PUSH_MEM;
					end

					OP_STORE, OP_ADD, OP_SUB, OP_GTR, OP_GTE, OP_EQ, OP_NEQ,
					OP_AND, OP_OR, OP_XOR:
					begin
						// Read next-on-stack first
						ctrl.ma_sel = MA_SP;
						state_next = ST_GOT_NOS;
					end

					OP_GOTO:
					begin
						ctrl.ip_sel = IP_BRANCH;
						state_next = ST_DECODE;
					end

					OP_BFALSE:
					begin
						// Redirect now and pop the condition in the next cycle
						ctrl.ip_sel = tos_zero ? IP_BRANCH : IP_NEXT;
						ctrl.sp_sel = SP_INCREMENT;
						ctrl.ma_sel = MA_SP;
						branch_pending_next = 1'b1;
						state_next = ST_PUSH_MEM;
					end

					default:
					begin
						ctrl.ip_sel = IP_NEXT;
						state_next = ST_DECODE;
					end
				endcase
			end

			ST_GOT_NOS:
			begin
				ctrl.sp_sel = SP_INCREMENT;
				if (opcode == OP_STORE)
				begin
					// Address in TOS, value in NOS
					ctrl.ma_sel = MA_TOS;
					ctrl.mw_sel = MW_MEM_READ;
					ctrl.write_enable = 1'b1;
					state_next = ST_LOAD_TOS;
				end
				else
				begin
					ctrl.tos_sel = TOS_ALU;
					ctrl.ip_sel = IP_NEXT;
					state_next = ST_DECODE;
				end
			end

			ST_LOAD_TOS:
			begin
				// Both operands consumed, refill TOS from memory
				ctrl.ma_sel = MA_SP;
				ctrl.sp_sel = SP_INCREMENT;
				state_next = ST_PUSH_MEM;
			end

			ST_PUSH_MEM:
			begin
				ctrl.tos_sel = TOS_MEM;
				ctrl.ip_sel = branch_pending ? IP_CURRENT : IP_NEXT;
				state_next = ST_DECODE;
			end

			default:
			begin
				state_next = ST_FETCH;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_FETCH;
			branch_pending <= 1'b0;
		end
		else
		begin
			state <= state_next;
			branch_pending <= branch_pending_next;
		end
	end

endmodule

`default_nettype wire

// ==== hw/lisp_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module lisp_core import lisp_pkg::*; #(
	parameter int MEM_SIZE = 8192,
	parameter int WORD_SIZE = 20
) (
	input  logic                   clk,
	input  logic                   rst,
	output logic [WORD_SIZE - 1:0] memory_address,
	input  logic [WORD_SIZE - 1:0] mem_read_value,
	output logic [WORD_SIZE - 1:0] mem_write_value,
	output logic                   mem_write_enable
);

	core_ctrl_t             ctrl;
	state_e                 state;
	opcode_e                opcode;
	logic [WORD_SIZE - 1:0] param;
	logic                   has_param;
	logic [WORD_SIZE - 1:0] alu_result;
	logic                   is_zero;
	logic [WORD_SIZE - 1:0] top_of_stack;
	logic [WORD_SIZE - 1:0] stack_pointer;
	logic [1:0]             ip_slot;
	logic                   tos_zero;

	insn_unpack #(
		.WORD_SIZE(WORD_SIZE)
	) u_unpack (
		.clk(clk),
		.rst(rst),
		.mem_read_value(mem_read_value),
		.state(state),
		.ip_slot(ip_slot),
		.opcode(opcode),
		.param(param),
		.has_param(has_param)
	);

	stack_alu #(
		.WORD_SIZE(WORD_SIZE)
	) u_alu (
		.ctrl(ctrl),
		.top_of_stack(top_of_stack),
		.stack_pointer(stack_pointer),
		.mem_read_value(mem_read_value),
		.param(param),
		.alu_result(alu_result),
		.is_zero(is_zero)
	);

	stack_datapath #(
		.MEM_SIZE(MEM_SIZE),
		.WORD_SIZE(WORD_SIZE)
	) u_datapath (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.param(param),
		.alu_result(alu_result),
		.mem_read_value(mem_read_value),
		.has_param(has_param),
		.is_zero(is_zero),
		.top_of_stack(top_of_stack),
		.stack_pointer(stack_pointer),
		.ip_slot(ip_slot),
		.tos_zero(tos_zero),
		.memory_address(memory_address),
		.mem_write_value(mem_write_value),
		.mem_write_enable(mem_write_enable)
	);

	stack_sequencer u_sequencer (
		.clk(clk),
		.rst(rst),
		.opcode(opcode),
		.tos_zero(tos_zero),
		.state(state),
		.ctrl(ctrl)
	);

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

	always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== test/lisp_core_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module lisp_core_assert #(
	parameter int WORD_SIZE = 20,
	parameter int PROG_WORDS = 256
) (
	input logic                   clk,
	input logic                   rst,
	input logic [WORD_SIZE - 1:0] memory_address,
	input logic                   mem_write_enable
);

	int fail_count = 0;

	a_write_enable_known: assert property (@(posedge clk) disable iff (rst)
		!$isunknown(mem_write_enable))
	else
	begin
		$error("mem_write_enable is unknown");
		fail_count++;
	end

	// Code lives in the low words and must never be overwritten
	a_no_program_write: assert property (@(posedge clk) disable iff (rst)
		mem_write_enable |-> memory_address >= WORD_SIZE'(PROG_WORDS))
	else
	begin
		$error("write landed in the program region at %h", memory_address);
		fail_count++;
	end

	a_first_fetch: assert property (@(posedge clk)
		$fell(rst) |-> (memory_address == '0 && !mem_write_enable))
	else
	begin
		$error("first cycle after reset did not fetch word 0");
		fail_count++;
	end

endmodule

bind lisp_core lisp_core_assert #(
	.WORD_SIZE(WORD_SIZE),
	.PROG_WORDS(256)
) u_assert (
	.clk(clk),
	.rst(rst),
	.memory_address(memory_address),
	.mem_write_enable(mem_write_enable)
);

`default_nettype wire

// ==== test/tb_lisp_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lisp_core import lisp_pkg::*; ();

	localparam int MEM_SIZE = 8192;
	localparam int WORD_SIZE = 20;
	localparam int ADDR_BITS = $clog2(MEM_SIZE);
	localparam int RES_BASE = 1024;
	localparam int RES_WORDS = 32;
	localparam int DONE_ADDR = 2047;
	localparam int NUM_TESTS = 4;

	logic                   clk;
	logic                   por_rst;
	logic                   hold_rst;
	logic                   rst;
	logic [WORD_SIZE - 1:0] memory_address;
	logic [WORD_SIZE - 1:0] mem_read_value = '0;
	logic [WORD_SIZE - 1:0] mem_write_value;
	logic                   mem_write_enable;

	logic [WORD_SIZE - 1:0] mem [MEM_SIZE];
	logic                   load_en;
	logic [ADDR_BITS - 1:0] load_addr;
	logic [WORD_SIZE - 1:0] load_data;

	logic [WORD_SIZE - 1:0] prog [$];
	logic [WORD_SIZE - 1:0] expected [RES_WORDS];
	int                     expect_writes;
	int                     result_writes;
	logic                   done_seen;
	logic [31:0]            lfsr_state = 32'h0e8d_57b9;
	int                     error_count = 0;
	int                     tests_failed = 0;

	assign rst = por_rst | hold_rst;

	tb_clock #(
		.PERIOD(20),
		.RESET_CYCLES(2)
	) u_clock (
		.clk(clk),
		.rst(por_rst)
	);

	lisp_core #(
		.MEM_SIZE(MEM_SIZE),
		.WORD_SIZE(WORD_SIZE)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.memory_address(memory_address),
		.mem_read_value(mem_read_value),
		.mem_write_value(mem_write_value),
		.mem_write_enable(mem_write_enable)
	);

	// Single-port memory with read data one cycle after the address
	always @(posedge clk)
	begin
		if (load_en)
			mem[load_addr] <= load_data;
		else if (mem_write_enable)
			mem[memory_address[ADDR_BITS - 1:0]] <= mem_write_value;
		mem_read_value <= mem[memory_address[ADDR_BITS - 1:0]];
	end

	function automatic logic in_result_area(logic [WORD_SIZE - 1:0] addr);
		return addr >= WORD_SIZE'(RES_BASE) && addr < WORD_SIZE'(RES_BASE + RES_WORDS);
	endfunction

	function automatic logic [WORD_SIZE - 1:0] expected_at(logic [WORD_SIZE - 1:0] addr);
		logic [WORD_SIZE - 1:0] offset;
		offset = addr - WORD_SIZE'(RES_BASE);
		return expected[offset[4:0]];
	endfunction

	always @(posedge clk)
	begin
		if (rst)
		begin
			done_seen <= 1'b0;
			result_writes <= 0;
		end
		else if (mem_write_enable)
		begin
			if (memory_address == WORD_SIZE'(DONE_ADDR))
				done_seen <= 1'b1;
			if (in_result_area(memory_address))
				result_writes <= result_writes + 1;
		end
	end

	a_result_value: assert property (@(posedge clk) disable iff (rst)
		(mem_write_enable && in_result_area(memory_address))
			|-> mem_write_value == expected_at(memory_address))
	else
	begin
		$display("Mismatch at %0d ns: mem_write_value at %h got %h expected %h", $time,
			$sampled(memory_address), $sampled(mem_write_value),
			expected_at($sampled(memory_address)));
		error_count++;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] value;
		logic        fb;
		value = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			value = {value[30:0], fb};
		end
		return value;
	endfunction

	function automatic logic [WORD_SIZE - 1:0] sign_extend(logic [WORD_SIZE - 1:0] raw, int w);
		logic [WORD_SIZE - 1:0] mask;
		mask = (WORD_SIZE'(1) << w) - WORD_SIZE'(1);
		if (raw[w - 1])
			return raw | ~mask;
		return raw & mask;
	endfunction

	// Slot s holds the opcode and the 15 - 5s bits below it hold the parameter
	task automatic emit_push(int slot, logic [WORD_SIZE - 1:0] value);
		int                     w;
		logic [WORD_SIZE - 1:0] mask;
		w = 15 - 5 * slot;
		mask = (WORD_SIZE'(1) << w) - WORD_SIZE'(1);
		prog.push_back((WORD_SIZE'(OP_PUSH) << w) | (value & mask));
	endtask

	task automatic emit_op(opcode_e op);
		prog.push_back({op, 15'd0});
	endtask

	task automatic emit_jump(opcode_e op, int offset);
		prog.push_back({op, 15'(offset)});
	endtask

	task automatic emit_result(int k, logic [WORD_SIZE - 1:0] value);
		emit_push(0, WORD_SIZE'(RES_BASE + k));
		emit_op(OP_STORE);
		expected[k] = value;
		expect_writes++;
	endtask

	// Marker store that must never execute
	task automatic emit_wrong_path(int k);
		emit_push(0, WORD_SIZE'(20'h0bad));
		emit_push(0, WORD_SIZE'(RES_BASE + k));
		emit_op(OP_STORE);
	endtask

	task automatic start_program();
		prog.delete();
		expect_writes = 0;
	endtask

	task automatic run_program(string name);
		int errors_before;
		emit_push(0, WORD_SIZE'(1));
		emit_push(0, WORD_SIZE'(DONE_ADDR));
		emit_op(OP_STORE);
		emit_jump(OP_GOTO, 0);
		@(posedge clk);
		hold_rst <= 1'b1;
		for (int i = 0; i < prog.size(); i++)
		begin
			@(posedge clk);
			load_en <= 1'b1;
			load_addr <= ADDR_BITS'(i);
			load_data <= prog[i];
		end
		@(posedge clk);
		load_en <= 1'b0;
		repeat (2) @(posedge clk);
		errors_before = error_count;
		hold_rst <= 1'b0;
		@(posedge clk);
		while (!done_seen)
			@(posedge clk);
		@(posedge clk);
		if (result_writes != expect_writes)
		begin
			$display("Test %s stored %0d results where %0d were expected", name,
				result_writes, expect_writes);
			error_count++;
		end
		if (error_count != errors_before)
			tests_failed++;
		$display("Test %s finished with %0d results and %0d errors", name, result_writes,
			error_count - errors_before);
	endtask

	task automatic test_arith();
		logic [WORD_SIZE - 1:0] a;
		logic [WORD_SIZE - 1:0] b;
		int                     sa;
		int                     sb;
		start_program();
		for (int i = 0; i < 6; i++)
		begin
			sa = i % 3;
			sb = (i + 1) % 3;
			a = sign_extend(WORD_SIZE'(rand_bits(15 - 5 * sa)), 15 - 5 * sa);
			b = sign_extend(WORD_SIZE'(rand_bits(15 - 5 * sb)), 15 - 5 * sb);
			emit_push(sa, a);
			emit_push(sb, b);
			if (i % 2 == 0)
			begin
				emit_op(OP_ADD);
				emit_result(i, a + b);
			end
			else
			begin
				// Top of stack minus the word beneath it
				emit_op(OP_SUB);
				emit_result(i, b - a);
			end
		end
		run_program("arith");
	endtask

	task automatic logic_case(int k, opcode_e op, logic [WORD_SIZE - 1:0] a,
		logic [WORD_SIZE - 1:0] b);
		logic [WORD_SIZE - 1:0] value;
		case (op)
			OP_AND: value = a & b;
			OP_OR: value = a | b;
			OP_XOR: value = a ^ b;
			OP_GTR: value = WORD_SIZE'($signed(b) > $signed(a));
			OP_GTE: value = WORD_SIZE'($signed(b) >= $signed(a));
			OP_EQ: value = WORD_SIZE'(b == a);
			default: value = WORD_SIZE'(b != a);
		endcase
		emit_push(0, a);
		emit_push(0, b);
		emit_op(op);
		emit_result(k, value);
	endtask

	task automatic test_logic();
		opcode_e                ops [7];
		logic [WORD_SIZE - 1:0] a;
		logic [WORD_SIZE - 1:0] b;
		ops = '{OP_AND, OP_OR, OP_XOR, OP_GTR, OP_GTE, OP_EQ, OP_NEQ};
		start_program();
		for (int i = 0; i < 7; i++)
		begin
			a = sign_extend(WORD_SIZE'(rand_bits(15)), 15);
			b = sign_extend(WORD_SIZE'(rand_bits(15)), 15);
			logic_case(i, ops[i], a, b);
		end
		// Equal operands hit the boundary of each compare
		a = sign_extend(WORD_SIZE'(rand_bits(15)), 15);
		logic_case(7, OP_EQ, a, a);
		logic_case(8, OP_GTE, a, a);
		logic_case(9, OP_GTR, a, a);
		logic_case(10, OP_NEQ, a, a);
		// Distinct operands in both orders make each ordered compare true once
		b = sign_extend(WORD_SIZE'(rand_bits(15)), 15);
		if (b == a)
			b = ~a;
		logic_case(11, OP_GTR, a, b);
		logic_case(12, OP_GTR, b, a);
		logic_case(13, OP_GTE, a, b);
		logic_case(14, OP_GTE, b, a);
		run_program("logic_compare");
	endtask

	task automatic test_branch();
		start_program();
		emit_jump(OP_GOTO, 4);
		emit_wrong_path(0);
		emit_push(0, WORD_SIZE'(20'h0a11));
		emit_result(0, WORD_SIZE'(20'h0a11));
		// Taken bfalse must keep the value beneath the condition
		emit_push(0, WORD_SIZE'(77));
		emit_push(0, WORD_SIZE'(0));
		emit_jump(OP_BFALSE, 4);
		emit_wrong_path(1);
		emit_push(0, WORD_SIZE'(20'h0b22));
		emit_result(1, WORD_SIZE'(20'h0b22));
		emit_result(2, WORD_SIZE'(77));
		emit_push(0, WORD_SIZE'(5));
		emit_jump(OP_BFALSE, 5);
		emit_push(0, WORD_SIZE'(20'h0c33));
		emit_result(3, WORD_SIZE'(20'h0c33));
		emit_jump(OP_GOTO, 4);
		emit_wrong_path(3);
		run_program("branch");
	endtask

	task automatic test_stack_ops();
		logic [WORD_SIZE - 1:0] v;
		logic [WORD_SIZE - 1:0] w;
		logic [WORD_SIZE - 1:0] a;
		start_program();
		v = sign_extend(WORD_SIZE'(rand_bits(15)), 15);
		emit_push(0, v);
		emit_op(OP_DUP);
		emit_op(OP_ADD);
		emit_result(0, v + v);
		w = sign_extend(WORD_SIZE'(rand_bits(10)), 10);
		emit_push(1, w);
		emit_result(1, w);
		emit_push(0, WORD_SIZE'(RES_BASE + 1));
		emit_op(OP_LOAD);
		emit_result(2, w);
		a = sign_extend(WORD_SIZE'(rand_bits(5)), 5);
		emit_push(2, a);
		emit_push(0, sign_extend(WORD_SIZE'(rand_bits(15)), 15));
		emit_op(OP_POP);
		emit_result(3, a);
		run_program("stack_ops");
	endtask

	initial
	begin
		#(NUM_TESTS * 400 * 20);
		$display("Watchdog expired before the tests finished");
		$display("** FAIL **");
		$finish;
	end

	initial
	begin
		hold_rst = 1'b1;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		@(negedge por_rst);
		test_arith();
		test_logic();
		test_branch();
		test_stack_ops();
		error_count += u_dut.u_assert.fail_count;
		$display("Tests run %0d, failed %0d, errors %0d", NUM_TESTS, tests_failed,
			error_count);
		if (error_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
hw/lisp_pkg.sv
hw/insn_unpack.sv
hw/stack_alu.sv
hw/stack_datapath.sv
hw/stack_sequencer.sv
hw/lisp_core.sv
test/tb_clock.sv
test/lisp_core_assert.sv
test/tb_lisp_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the lisp_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_lisp_core \
	-o tb_lisp_core_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/tb_lisp_core_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "\*\* FAIL \*\*" sim.log; then
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi
exit 0
